// ==== compile.f ====
src/dc_pkg.sv
src/dc_pix_fifo.sv
src/dc_raster_timer.sv
src/dc_frame_ctl.sv
src/dc_adout.sv
src/dc_top.sv
tb/dc_checker.sv
tb/tb_dc.sv

// ==== Makefile ====
TOP = tb_dc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f compile.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f compile.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir

// ==== tb/tb_dc.sv ====
`default_nettype none

module tb_dc import dc_pkg::*;;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int limit_cycles = 6 * h_total * v_total + 200;
  localparam int st_idle = 0;
  localparam int st_pre = 1;
  localparam int st_disp = 2;
  localparam int st_under = 3;

  logic        pixclock = 1'b0;
  logic        hnreset;
  logic        wr;
  crt_word_t   wdata;
  bpp_t        bpp;
  logic        vga_en;
  logic [7:0]  vga_din;
  logic [9:0]  ff_stp;
  logic [9:0]  ff_rls;
  logic [10:0] ovtl_y;
  logic [10:0] ovbr_y;
  pixel_t      datdc_out;
  logic        blank_out;
  logic        underrun;
  logic        full;

  logic        wr_en;
  logic [31:0] rng;
  logic [31:0] vga_rng;
  int          cycles;

  // model state, one cycle of the DUT per rising edge.
  crt_word_t   fifo_q[$];
  int          m_h;
  int          m_v;
  logic        m_cb;
  logic        m_vs;
  logic        m_rs;
  logic        m_fs;
  int          m_st;
  logic [3:0]  m_pos;
  logic [3:0]  m_inc;
  logic [9:0]  m_pc;
  logic [11:0] m_lc;
  logic        m_hd;
  logic        m_vd;
  crt_word_t   m_word;
  pixel_t      pipe_pix[3];
  logic        pipe_blank[3];
  logic        pipe_ok[3];
  logic [7:0]  vga_prev;
  pixel_t      exp_pix;
  logic        exp_blank;
  logic        exp_ok;
  logic        exp_under;
  logic        exp_full;
  logic        started;

  dc_top i_dut (
    .pixclock  (pixclock),
    .hnreset   (hnreset),
    .wr        (wr),
    .wdata     (wdata),
    .bpp       (bpp),
    .vga_en    (vga_en),
    .vga_din   (vga_din),
    .ff_stp    (ff_stp),
    .ff_rls    (ff_rls),
    .ovtl_y    (ovtl_y),
    .ovbr_y    (ovbr_y),
    .datdc_out (datdc_out),
    .blank_out (blank_out),
    .underrun  (underrun),
    .full      (full)
  );

  always #20 pixclock = ~pixclock;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // slot by pos[3:2], then a byte, a halfword or 24 bits of the slot.
  function automatic pixel_t ref_pixel(input crt_word_t w, input bpp_t b, input logic [3:0] pos);
    logic [31:0] slot;
    logic [7:0]  byte_v;
    logic [15:0] half;
    slot   = w[pos[3:2]*32 +: 32];
    byte_v = slot[pos[1:0]*8 +: 8];
    half   = slot[pos[1]*16 +: 16];
    if (b == bpp_8) begin
      return {3{byte_v}};
    end else if (b == bpp_16) begin
      return {8'h00, half};
    end
    return slot[23:0];
  endfunction

  task automatic check_pixel(input string name, input pixel_t expv, input pixel_t actv);
    if (expv !== actv) begin
      $display("FAILED %s expected %h actual %h", name, expv, actv);
      $display("TB FAILED");
      $fatal(1, "pixel mismatch");
    end
  endtask

  task automatic check_flag(input string name, input logic expv, input logic actv);
    if (expv !== actv) begin
      $display("FAILED %s expected %h actual %h", name, expv, actv);
      $display("TB FAILED");
      $fatal(1, "flag mismatch");
    end
  endtask

  task automatic wait_line(input int line);
    @(negedge pixclock);
    while (!(m_v == line && m_h == 0)) begin
      @(negedge pixclock);
    end
    @(posedge pixclock);
    #2;
  endtask

  initial begin
    hnreset = 1'b0;
    wr = 1'b0;
    wdata = '0;
    bpp = bpp_8;
    vga_en = 1'b0;
    vga_din = 8'h00;
    ff_stp = '1;        // window off until frame 4.
    ff_rls = '1;
    ovtl_y = '1;
    ovbr_y = '1;
    wr_en = 1'b0;
    rng = 32'd91;
    vga_rng = 32'd91 ^ 32'h5a5a;
    cycles = 0;
    m_h = 0;
    m_v = 0;
    m_cb = 1'b0;
    m_vs = 1'b1;
    m_rs = 1'b0;
    m_fs = 1'b0;
    m_st = st_idle;
    m_pos = '0;
    m_inc = '0;
    m_pc = '0;
    m_lc = '0;
    m_hd = 1'b0;
    m_vd = 1'b0;
    m_word = '0;
    vga_prev = 8'h00;
    exp_pix = '0;
    exp_blank = 1'b0;
    exp_ok = 1'b0;
    exp_under = 1'b0;
    exp_full = 1'b0;
    started = 1'b0;
    for (int i = 0; i < 3; i++) begin
      pipe_pix[i] = '0;
      pipe_blank[i] = 1'b0;
      pipe_ok[i] = 1'b0;
    end
    repeat (10) @(posedge pixclock);
    #2 hnreset = 1'b1;
    @(posedge pixclock);
    #1 wr_en = 1'b1;
    wait_line(8);
    bpp = bpp_16;
    wait_line(8);
    bpp = bpp_32;
    wait_line(8);
    bpp = bpp_8;
    ff_stp = 10'd3;
    ff_rls = 10'd5;
    ovtl_y = 11'd2;
    ovbr_y = 11'd4;
    wait_line(6);
    vga_en = 1'b1;
    for (int i = 0; i < h_total; i++) begin
      vga_rng = lcg_next(vga_rng);
      vga_din = vga_rng[23:16];
      @(posedge pixclock);
      #2;
    end
    vga_en = 1'b0;
    wait_line(8);
    ff_stp = '1;
    ff_rls = '1;
    ovtl_y = '1;
    ovbr_y = '1;
    wait_line(1);
    wr_en = 1'b0;       // the FIFO drains within a few lines.
    while (!underrun) begin
      @(negedge pixclock);
    end
    wr_en = 1'b1;
    while (underrun) begin
      @(negedge pixclock);
    end
    wait_line(4);
    $display("TB PASSED");
    $finish;
  end

  always @(posedge pixclock) begin
    #2;
    if (hnreset && wr_en && !full) begin
      wr = 1'b1;
      for (int k = 0; k < 4; k++) begin
        rng = lcg_next(rng);
        wdata[k*32 +: 32] = rng;
      end
    end else begin
      wr = 1'b0;
    end
  end

  always @(posedge pixclock) begin
    logic      dcn;
    logic      act;
    logic      pop_m;
    logic      emp;
    logic      full_n;
    logic      ok_n;
    crt_word_t cur;
    pixel_t    pix_n;
    if (hnreset) begin
      cycles++;
      if (cycles > limit_cycles) begin
        $display("simulation timed out after %0d cycles", cycles);
        $display("TB FAILED");
        $fatal(1, "timeout");
      end
      dcn = (m_st == st_disp) || (m_st == st_under);
      emp = (fifo_q.size() == 0);
      full_n = (fifo_q.size() == fifo_depth);
      act = !(m_hd && m_vd && m_cb && m_rs);
      pop_m = dcn && m_cb && act && (m_pos == 4'd0);
      cur = (pop_m && !emp) ? fifo_q[0] : m_word;
      pix_n = ref_pixel(cur, bpp, m_pos);
      ok_n = (m_st == st_disp) && !(pop_m && emp);
      case (m_st)
        st_idle:  if (m_fs) m_st = st_pre;
        st_pre:   if (fifo_q.size() >= prefill_lvl && !m_cb) m_st = st_disp;
        st_disp:  if (pop_m && emp) m_st = st_under;
        default:  if (m_fs) m_st = st_pre;
      endcase
      if (!dcn) begin
        m_pos = '0;
        m_lc = '0;
        m_pc = '0;
        m_hd = 1'b0;
        m_vd = 1'b0;
      end else begin
        if (m_pc == ff_stp) m_hd = 1'b1;
        else if (m_pc == ff_rls || !m_cb) m_hd = 1'b0;
        if (m_lc == {1'b0, ovtl_y}) m_vd = 1'b1;
        else if (m_lc == {1'b0, ovbr_y} + 12'd1 || !m_vs) m_vd = 1'b0;
        if (!(m_vs && m_rs)) m_lc = '0;
        else if (pipe_blank[0] && !m_cb) m_lc = m_lc + 12'd1;   // one per finished line.
        if (!(m_vs && m_cb && m_rs)) m_pc = '0;
        else if (pop_m) m_pc = m_pc + 10'd1;
        if (!(m_vs && m_cb)) m_pos = '0;
        else if (act) m_pos = m_pos + m_inc;
      end
      if (act) m_inc = (bpp == bpp_8) ? 4'd1 : (bpp == bpp_16) ? 4'd2 : 4'd4;
      pipe_pix[2] = pipe_pix[1];
      pipe_pix[1] = pipe_pix[0];
      pipe_pix[0] = pix_n;
      pipe_ok[2] = pipe_ok[1];
      pipe_ok[1] = pipe_ok[0];
      pipe_ok[0] = ok_n;
      pipe_blank[2] = dcn && pipe_blank[1];
      pipe_blank[1] = dcn && pipe_blank[0];
      pipe_blank[0] = dcn && m_cb;
      exp_pix = vga_en ? {3{vga_prev}} : pipe_pix[2];
      exp_blank = pipe_blank[2];
      exp_ok = pipe_ok[2];
      vga_prev = vga_din;
      if (pop_m && !emp) begin
        m_word = cur;
        void'(fifo_q.pop_front());
      end
      if (wr && !full_n) fifo_q.push_back(wdata);
      exp_full = (fifo_q.size() == fifo_depth);
      exp_under = (m_st == st_under);
      if (m_st == st_disp) started = 1'b1;
      m_cb = (m_v < v_active) && (m_h < h_active);
      m_vs = !((m_v >= v_active) && (m_v < v_active + v_sync_lines));
      m_rs = (m_v < v_active);
      m_fs = (m_h == 0) && (m_v == 0);
      if (m_h == h_total - 1) begin
        m_h = 0;
        m_v = (m_v == v_total - 1) ? 0 : m_v + 1;
      end else begin
        m_h = m_h + 1;
      end
    end
  end

  always @(negedge pixclock) begin
    check_flag("blank_out", exp_blank, blank_out);
    check_flag("underrun", exp_under, underrun);
    check_flag("full", exp_full, full);
    if (!started) begin
      check_pixel("datdc_out", '0, datdc_out);
    end else if (exp_blank && exp_ok) begin
      check_pixel("datdc_out", exp_pix, datdc_out);
    end
  end

endmodule

`default_nettype wire

// ==== tb/dc_checker.sv ====
`default_nettype none

module dc_checker import dc_pkg::*; (
  input wire logic                  pixclock,
  input wire logic                  hnreset,
  input wire logic                  dcnreset,
  input wire logic [fifo_lvl_w-1:0] level,
  input wire logic                  wr,
  input wire logic                  full,
  input wire logic                  cblank,
  input wire logic                  blank_out
);
  timeunit 1ns;
  timeprecision 100ps;

  // display is enabled only once the FIFO holds the prefill words.
  a_prefill_level: assert property (@(posedge pixclock) disable iff (!hnreset)
    $rose(dcnreset) |-> (level >= fifo_lvl_w'(prefill_lvl)))
    else $error("display enabled before the FIFO was prefilled");

  a_write_full: assert property (@(posedge pixclock) disable iff (!hnreset)
    !(wr && full))
    else $error("write strobe while the FIFO is full");

  // the blank delay line is cleared while dcnreset is low.
  a_blank_align: assert property (@(posedge pixclock) disable iff (!hnreset)
    ($past(dcnreset, 1) && $past(dcnreset, 2) && $past(dcnreset, 3))
    |-> (blank_out == $past(cblank, 3)))
    else $error("blank_out is not cblank delayed by three cycles");

endmodule

bind dc_top dc_checker i_chk (
  .pixclock  (pixclock),
  .hnreset   (hnreset),
  .dcnreset  (dcnreset),
  .level     (level),
  .wr        (wr),
  .full      (full),
  .cblank    (cblank),
  .blank_out (blank_out)
);

`default_nettype wire

// ==== src/dc_top.sv ====
`default_nettype none

module dc_top import dc_pkg::*; (
  input  wire logic        pixclock,
  input  wire logic        hnreset,
  input  wire logic        wr,
  input  wire crt_word_t   wdata,
  input  wire bpp_t        bpp,
  input  wire logic        vga_en,
  input  wire logic [7:0]  vga_din,
  input  wire logic [9:0]  ff_stp,
  input  wire logic [9:0]  ff_rls,
  input  wire logic [10:0] ovtl_y,
  input  wire logic [10:0] ovbr_y,
  output pixel_t           datdc_out,
  output logic             blank_out,
  output logic             underrun,
  output logic             full
);

  crt_word_t             rdata;
  logic                  empty;
  logic [fifo_lvl_w-1:0] level;
  logic                  pop;
  logic                  vsync;
  logic                  cblank;
  logic                  rsuppr;
  logic                  frame_start;
  logic                  dcnreset;

  dc_pix_fifo u_fifo (
    .pixclock (pixclock),
    .hnreset  (hnreset),
    .wr       (wr),
    .wdata    (wdata),
    .pop      (pop),
    .rdata    (rdata),
    .full     (full),
    .empty    (empty),
    .level    (level)
  );

  dc_raster_timer u_raster (
    .pixclock    (pixclock),
    .hnreset     (hnreset),
    .vsync       (vsync),
    .cblank      (cblank),
    .rsuppr      (rsuppr),
    .frame_start (frame_start)
  );

  dc_frame_ctl u_frame (
    .pixclock    (pixclock),
    .hnreset     (hnreset),
    .frame_start (frame_start),
    .cblank      (cblank),
    .pop         (pop),
    .empty       (empty),
    .level       (level),
    .dcnreset    (dcnreset),
    .underrun    (underrun)
  );

  dc_adout u_adout (
    .pixclock  (pixclock),
    .hnreset   (hnreset),
    .dcnreset  (dcnreset),
    .vsync     (vsync),
    .cblank    (cblank),
    .rsuppr    (rsuppr),
    .ff_stp    (ff_stp),
    .ff_rls    (ff_rls),
    .ovtl_y    (ovtl_y),
    .ovbr_y    (ovbr_y),
    .bpp       (bpp),
    .crt_data  (rdata),
    .vga_din   (vga_din),
    .vga_en    (vga_en),
    .datdc_out (datdc_out),
    .pop       (pop),
    .blank_out (blank_out)
  );

endmodule

`default_nettype wire

// ==== src/dc_adout.sv ====
`default_nettype none

module dc_adout import dc_pkg::*; (
  input  wire logic        pixclock,
  input  wire logic        hnreset,
  input  wire logic        dcnreset,
  input  wire logic        vsync,
  input  wire logic        cblank,
  input  wire logic        rsuppr,
  input  wire logic [9:0]  ff_stp,
  input  wire logic [9:0]  ff_rls,
  input  wire logic [10:0] ovtl_y,
  input  wire logic [10:0] ovbr_y,
  input  wire bpp_t        bpp,
  input  wire crt_word_t   crt_data,
  input  wire logic [7:0]  vga_din,
  input  wire logic        vga_en,
  output pixel_t           datdc_out,
  output logic             pop,
  output logic             blank_out
);

  logic [3:0]  counter;      // byte position inside the current word.
  logic [3:0]  inc;
  logic [3:0]  out_sel0;
  logic [1:0]  out_sel;
  logic [2:0]  blank_dly;
  logic [11:0] lcount;
  logic [9:0]  pcount;
  logic        hdisbl;
  logic        vdisbl;
  crt_word_t   word_q;
  logic [31:0] crt_dat;
  logic [7:0]  vga_store;
  logic [11:0] ff_yrls;
  logic        active;

  assign active    = !(hdisbl && vdisbl && cblank && rsuppr);
  assign pop       = dcnreset && cblank && active && (counter == 4'd0);
  assign ff_yrls   = {1'b0, ovbr_y} + 12'd1;
  assign blank_out = blank_dly[2];

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      inc <= 4'd0;
    end else if (active) begin
      case (bpp)
        bpp_8:            inc <= 4'd1;
        bpp_16:           inc <= 4'd2;
        bpp_32, bpp_32_hi: inc <= 4'd4;
        default:          inc <= 4'd4;
      endcase
    end
  end

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      counter <= 4'd0;
    end else if (!dcnreset || !(vsync && cblank)) begin
      counter <= 4'd0;
    end else if (active) begin
      counter <= counter + inc;   // wraps to zero at the end of a word.
    end
  end

  // popped word is held here since the FIFO head moves on the same edge.
  always_ff @(posedge pixclock) begin
    if (!dcnreset) begin
      word_q  <= '0;
      crt_dat <= '0;
    end else begin
      if (pop) begin
        word_q <= crt_data;
      end
      crt_dat <= word_q[out_sel0[3:2]*32 +: 32];
    end
  end

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      blank_dly <= '0;
      out_sel0  <= '0;
      out_sel   <= '0;
      lcount    <= '0;
      pcount    <= '0;
      hdisbl    <= 1'b0;
      vdisbl    <= 1'b0;
    end else if (!dcnreset) begin
      blank_dly <= '0;
      out_sel0  <= '0;
      out_sel   <= '0;
      lcount    <= '0;
      pcount    <= '0;
      hdisbl    <= 1'b0;
      vdisbl    <= 1'b0;
    end else begin
      blank_dly <= {blank_dly[1:0], cblank};   // matches the three-stage data path.
      out_sel0  <= counter;
      out_sel   <= out_sel0[1:0];
      if (!(vsync && rsuppr)) begin
        lcount <= '0;
      end else if (blank_dly[0] && !cblank) begin
        lcount <= lcount + 12'd1;              // counted at each line end.
      end
      if (!(vsync && cblank && rsuppr)) begin
        pcount <= '0;
      end else if (pop) begin
        pcount <= pcount + 10'd1;
      end
      if (pcount == ff_stp) begin
        hdisbl <= 1'b1;
      end else if ((pcount == ff_rls) || !cblank) begin
        hdisbl <= 1'b0;
      end
      if (lcount == {1'b0, ovtl_y}) begin
        vdisbl <= 1'b1;
      end else if ((lcount == ff_yrls) || !vsync) begin
        vdisbl <= 1'b0;
      end
    end
  end

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      vga_store <= 8'h0;
      datdc_out <= '0;
    end else begin
      vga_store <= vga_din;
      if (vga_en) begin
        datdc_out <= {3{vga_store}};
      end else begin
        case (bpp)
          bpp_8:   datdc_out <= {3{crt_dat[out_sel*8 +: 8]}};
          bpp_16:  datdc_out <= {8'h0, crt_dat[out_sel[1]*16 +: 16]};
          default: datdc_out <= crt_dat[23:0];
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/dc_frame_ctl.sv ====
`default_nettype none

module dc_frame_ctl import dc_pkg::*; (
  input  wire logic                  pixclock,
  input  wire logic                  hnreset,
  input  wire logic                  frame_start,
  input  wire logic                  cblank,
  input  wire logic                  pop,
  input  wire logic                  empty,
  input  wire logic [fifo_lvl_w-1:0] level,
  output logic                       dcnreset,
  output logic                       underrun
);

  typedef enum logic [1:0] {
    st_idle,
    st_prefill,
    st_display,
    st_underrun
  } state_t;

  state_t state_q;
  state_t state_d;

  always_comb begin
    state_d = state_q;
    case (state_q)
      st_idle:     if (frame_start) state_d = st_prefill;
      // release only in blanking so no line starts half drawn.
      st_prefill:  if ((level >= fifo_lvl_w'(prefill_lvl)) && !cblank) state_d = st_display;
      st_display:  if (pop && empty) state_d = st_underrun;
      st_underrun: if (frame_start) state_d = st_prefill;
      default:     state_d = st_idle;
    endcase
  end

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      state_q <= st_idle;
    end else begin
      state_q <= state_d;
    end
  end

  assign dcnreset = (state_q == st_display) || (state_q == st_underrun);
  assign underrun = (state_q == st_underrun);   // sticky until the next frame.

endmodule

`default_nettype wire

// ==== src/dc_raster_timer.sv ====
`default_nettype none

module dc_raster_timer import dc_pkg::*; (
  input  wire logic pixclock,
  input  wire logic hnreset,
  output logic      vsync,
  output logic      cblank,
  output logic      rsuppr,
  output logic      frame_start
);

  logic [h_cnt_w-1:0] hcnt;
  logic [v_cnt_w-1:0] vcnt;
  logic               line_end;
  logic               frame_end;
  logic               in_vsync;

  assign line_end  = (hcnt == h_cnt_w'(h_total - 1));
  assign frame_end = (vcnt == v_cnt_w'(v_total - 1));
  assign in_vsync  = (vcnt >= v_cnt_w'(v_active)) &&
                     (vcnt < v_cnt_w'(v_active + v_sync_lines));

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      hcnt <= '0;
      vcnt <= '0;
    end else if (line_end) begin
      hcnt <= '0;
      if (frame_end) begin
        vcnt <= '0;
      end else begin
        vcnt <= vcnt + 1'b1;
      end
    end else begin
      hcnt <= hcnt + 1'b1;
    end
  end

  // outputs trail the counters by one cycle, all of them alike.
  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      vsync       <= 1'b1;
      cblank      <= 1'b0;
      rsuppr      <= 1'b0;
      frame_start <= 1'b0;
    end else begin
      vsync       <= !in_vsync;
      rsuppr      <= (vcnt < v_cnt_w'(v_active));
      cblank      <= (vcnt < v_cnt_w'(v_active)) &&
                     (hcnt < h_cnt_w'(h_active));   // high means display.
      frame_start <= (hcnt == '0) && (vcnt == '0);
    end
  end

endmodule

`default_nettype wire

// ==== src/dc_pix_fifo.sv ====
`default_nettype none

module dc_pix_fifo import dc_pkg::*; (
  input  wire logic                  pixclock,
  input  wire logic                  hnreset,
  input  wire logic                  wr,
  input  wire crt_word_t             wdata,
  input  wire logic                  pop,
  output crt_word_t                  rdata,
  output logic                       full,
  output logic                       empty,
  output logic [fifo_lvl_w-1:0]      level
);

  crt_word_t             mem [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr;
  logic [fifo_ptr_w-1:0] rd_ptr;
  logic                  do_wr;
  logic                  do_rd;

  assign full  = (level == fifo_lvl_w'(fifo_depth));
  assign empty = (level == '0);
  assign do_wr = wr && !full;      // a write while full is lost.
  assign do_rd = pop && !empty;
  assign rdata = mem[rd_ptr];      // head word is always visible.

  always_ff @(posedge pixclock) begin
    if (do_wr) begin
      mem[wr_ptr] <= wdata;
    end
  end

  always_ff @(posedge pixclock or negedge hnreset) begin
    if (!hnreset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      level  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;   // depth is a power of two, so this wraps.
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/dc_pkg.sv ====
`default_nettype none

package dc_pkg;

  localparam int crt_w = 128;          // one frame-buffer word.
  localparam int pix_w = 24;           // one rgb pixel.

  localparam int h_active = 64;
  localparam int h_total = 80;
  localparam int v_active = 8;
  localparam int v_total = 10;
  localparam int v_sync_lines = 1;     // vsync low at the start of vertical blank.

  localparam int h_cnt_w = $clog2(h_total);
  localparam int v_cnt_w = $clog2(v_total);

  localparam int fifo_depth = 16;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_lvl_w = 5;
  localparam int prefill_lvl = 8;      // words needed before the display reset drops.

  typedef logic [crt_w-1:0] crt_word_t;
  typedef logic [pix_w-1:0] pixel_t;

  // codes 0 and 3 both select 32 bits per pixel.
  typedef enum logic [1:0] {
    bpp_32    = 2'd0,
    bpp_8     = 2'd1,
    bpp_16    = 2'd2,
    bpp_32_hi = 2'd3
  } bpp_t;

endpackage

`default_nettype wire
